// ==== logic/uart_pkg.sv ====
// uart transmit bank constants for channel count, frame format, baud division and fsm codes
package uart_pkg;

   // bank geometry
   localparam int num_channels = 4;
   localparam int chan_w = 2;

   // one start bit, lsb-first data and one stop bit
   localparam int data_bits = 8;
   localparam int oversample = 16;
   localparam int stop_ticks = 16;

   // system clocks per oversampling tick
   localparam int baud_divisor = 4;

   // sent-frame counter width
   localparam int count_w = 16;

   // counter widths
   localparam int div_w = $clog2(baud_divisor);
   localparam int tick_w = $clog2(oversample);
   localparam int bit_w = $clog2(data_bits);

   // terminal counts
   localparam logic [div_w-1:0] div_last = div_w'(baud_divisor - 1);
   localparam logic [tick_w-1:0] tick_last = tick_w'(oversample - 1);
   localparam logic [tick_w-1:0] stop_last = tick_w'(stop_ticks - 1);
   localparam logic [bit_w-1:0] bit_last = bit_w'(data_bits - 1);

   // transmitter states
   localparam logic [1:0] st_idle = 2'b00;
   localparam logic [1:0] st_start = 2'b01;
   localparam logic [1:0] st_data = 2'b10;
   localparam logic [1:0] st_stop = 2'b11;

endpackage

// ==== logic/baud_tick_gen.sv ====
// baud divider that emits the single-cycle oversampling tick shared by every channel
module baud_tick_gen
(
   input  logic clk,
   input  logic reset,
   output logic s_tick
);

   logic [uart_pkg::div_w-1:0] div_cnt;

   // free running once reset is released
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         div_cnt <= '0;
      end
      else if (s_tick)
      begin
         div_cnt <= '0;
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // tick on the last count of each period
   assign s_tick = (div_cnt == uart_pkg::div_last);

endmodule

// ==== logic/tx_dispatch.sv ====
// transmit dispatcher holding one byte per channel, flagging overruns and issuing starts
module tx_dispatch
(
   input  logic                                               clk,
   input  logic                                               reset,
   input  logic                                               wr_en,
   input  logic [uart_pkg::chan_w-1:0]                        wr_channel,
   input  logic [uart_pkg::data_bits-1:0]                     wr_data,
   input  logic [uart_pkg::num_channels-1:0]                  tx_ready,
   output logic [uart_pkg::num_channels-1:0]                  buf_full,
   output logic                                               overrun,
   output logic [uart_pkg::num_channels-1:0]                  tx_start,
   output logic [uart_pkg::num_channels*uart_pkg::data_bits-1:0] tx_data
);

   logic [uart_pkg::num_channels-1:0] wr_sel;
   logic [uart_pkg::num_channels-1:0] wr_accept;
   logic [uart_pkg::num_channels-1:0] launch;
   logic [uart_pkg::num_channels-1:0] full_next;
   logic                              wr_blocked;

   // one-hot decode of the addressed channel
   always_comb
   begin
      wr_sel = '0;
      wr_sel[wr_channel] = wr_en;
   end

   // a write only lands in an empty buffer
   assign wr_accept = wr_sel & ~buf_full;
   assign wr_blocked = |(wr_sel & buf_full);

   // hand over when the byte is waiting and the transmitter sits idle
   assign launch = buf_full & tx_ready;

   // launch needs a full buffer and accept an empty one so they never meet
   always_comb
   begin
      full_next = buf_full;
      for (int ch = 0; ch < uart_pkg::num_channels; ch++)
      begin
         if (launch[ch])
         begin
            full_next[ch] = 1'b0;
         end
         else if (wr_accept[ch])
         begin
            full_next[ch] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         buf_full <= '0;
         tx_start <= '0;
         overrun <= 1'b0;
      end
      else
      begin
         buf_full <= full_next;
         tx_start <= launch;
         overrun <= wr_blocked;
      end
   end

   // a held byte stays put until the next accepted write to its slice
   // so it is still valid on the cycle the transmitter latches it
   always_ff @(posedge clk)
   begin
      for (int ch = 0; ch < uart_pkg::num_channels; ch++)
      begin
         if (wr_accept[ch])
         begin
            tx_data[ch*uart_pkg::data_bits +: uart_pkg::data_bits] <= wr_data;
         end
      end
   end

endmodule

// ==== logic/uart_tx.sv ====
// oversampled uart transmitter sending start, eight data bits lsb first and one stop bit
module uart_tx
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          tx_start,
   input  logic                          s_tick,
   input  logic [uart_pkg::data_bits-1:0] din,
   output logic                          tx_ready,
   output logic                          tx_done,
   output logic                          tx
);

   logic [1:0]                    state_reg;
   logic [1:0]                    state_next;
   logic [uart_pkg::tick_w-1:0]   s_reg;
   logic [uart_pkg::tick_w-1:0]   s_next;
   logic [uart_pkg::bit_w-1:0]    n_reg;
   logic [uart_pkg::bit_w-1:0]    n_next;
   logic [uart_pkg::data_bits-1:0] b_reg;
   logic [uart_pkg::data_bits-1:0] b_next;
   logic                          tx_reg;
   logic                          tx_next;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg <= uart_pkg::st_idle;
         s_reg <= '0;
         n_reg <= '0;
         tx_reg <= 1'b1;
      end
      else
      begin
         state_reg <= state_next;
         s_reg <= s_next;
         n_reg <= n_next;
         tx_reg <= tx_next;
      end
   end

   // shift register
   always_ff @(posedge clk)
   begin
      b_reg <= b_next;
   end

   always_comb
   begin
      state_next = state_reg;
      s_next = s_reg;
      n_next = n_reg;
      b_next = b_reg;
      tx_next = tx_reg;
      tx_done = 1'b0;
      case (state_reg)
         uart_pkg::st_idle:
         begin
            tx_next = 1'b1;
            if (tx_start)
            begin
               state_next = uart_pkg::st_start;
               s_next = '0;
               b_next = din;
            end
         end
         uart_pkg::st_start:
         begin
            tx_next = 1'b0;
            if (s_tick)
            begin
               if (s_reg == uart_pkg::tick_last)
               begin
                  state_next = uart_pkg::st_data;
                  s_next = '0;
                  n_next = '0;
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         uart_pkg::st_data:
         begin
            tx_next = b_reg[0];
            if (s_tick)
            begin
               if (s_reg == uart_pkg::tick_last)
               begin
                  s_next = '0;
                  b_next = b_reg >> 1;
                  if (n_reg == uart_pkg::bit_last)
                  begin
                     state_next = uart_pkg::st_stop;
                  end
                  else
                  begin
                     n_next = n_reg + 1'b1;
                  end
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
         default:
         begin
            // stop bit with done on its last tick
            tx_next = 1'b1;
            if (s_tick)
            begin
               if (s_reg == uart_pkg::stop_last)
               begin
                  state_next = uart_pkg::st_idle;
                  tx_done = 1'b1;
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         end
      endcase
   end

   assign tx_ready = (state_reg == uart_pkg::st_idle);
   assign tx = tx_reg;

endmodule

// ==== logic/tx_done_collector.sv ====
// completion collector with sticky per-channel flags, interrupt level and sent-frame count
module tx_done_collector
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic [uart_pkg::num_channels-1:0] tx_done,
   input  logic [uart_pkg::num_channels-1:0] done_clear,
   output logic [uart_pkg::num_channels-1:0] done_flags,
   output logic                              irq,
   output logic [uart_pkg::count_w-1:0]      sent_count
);

   logic [uart_pkg::count_w-1:0] done_num;

   // population count of this cycle's done pulses
   always_comb
   begin
      done_num = '0;
      for (int ch = 0; ch < uart_pkg::num_channels; ch++)
      begin
         done_num = done_num + {{(uart_pkg::count_w - 1){1'b0}}, tx_done[ch]};
      end
   end

   // set wins over clear in the same cycle
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         done_flags <= '0;
      end
      else
      begin
         done_flags <= (done_flags & ~done_clear) | tx_done;
      end
   end

   // wraps silently at full scale
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         sent_count <= '0;
      end
      else
      begin
         sent_count <= sent_count + done_num;
      end
   end

   assign irq = |done_flags;

endmodule

// ==== logic/uart_tx_bank.sv ====
// four-channel uart transmit bank with shared baud tick, dispatcher and completion collector
module uart_tx_bank
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              wr_en,
   input  logic [uart_pkg::chan_w-1:0]       wr_channel,
   input  logic [uart_pkg::data_bits-1:0]    wr_data,
   input  logic [uart_pkg::num_channels-1:0] done_clear,
   output logic [uart_pkg::num_channels-1:0] buf_full,
   output logic                              overrun,
   output logic [uart_pkg::num_channels-1:0] tx,
   output logic [uart_pkg::num_channels-1:0] done_flags,
   output logic                              irq,
   output logic [uart_pkg::count_w-1:0]      sent_count
);

   logic                                               s_tick;
   logic [uart_pkg::num_channels-1:0]                  tx_start;
   logic [uart_pkg::num_channels-1:0]                  tx_ready;
   logic [uart_pkg::num_channels-1:0]                  tx_done;
   logic [uart_pkg::num_channels*uart_pkg::data_bits-1:0] tx_data;

   baud_tick_gen u_baud_tick_gen
   (
      .clk    (clk),
      .reset  (reset),
      .s_tick (s_tick)
   );

   tx_dispatch u_tx_dispatch
   (
      .clk        (clk),
      .reset      (reset),
      .wr_en      (wr_en),
      .wr_channel (wr_channel),
      .wr_data    (wr_data),
      .tx_ready   (tx_ready),
      .buf_full   (buf_full),
      .overrun    (overrun),
      .tx_start   (tx_start),
      .tx_data    (tx_data)
   );

   // one transmitter per channel on the shared tick
   for (genvar ch = 0; ch < uart_pkg::num_channels; ch++)
   begin : g_chan
      uart_tx u_uart_tx
      (
         .clk      (clk),
         .reset    (reset),
         .tx_start (tx_start[ch]),
         .s_tick   (s_tick),
         .din      (tx_data[ch*uart_pkg::data_bits +: uart_pkg::data_bits]),
         .tx_ready (tx_ready[ch]),
         .tx_done  (tx_done[ch]),
         .tx       (tx[ch])
      );
   end

   tx_done_collector u_tx_done_collector
   (
      .clk        (clk),
      .reset      (reset),
      .tx_done    (tx_done),
      .done_clear (done_clear),
      .done_flags (done_flags),
      .irq        (irq),
      .sent_count (sent_count)
   );

endmodule

// ==== tests/uart_line_monitor.sv ====
// serial line monitor that captures each ten-bit uart frame by sampling at mid-bit
module uart_line_monitor
(
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            line,
   output logic                            frame_valid,
   output logic [uart_pkg::data_bits+1:0]  frame
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int bit_clocks = uart_pkg::oversample * uart_pkg::baud_divisor;
   localparam int frame_bits = uart_pkg::data_bits + 2;

   logic busy;
   logic line_q;
   int   cnt;
   int   idx;

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         line_q <= 1'b1;
         cnt <= 0;
         idx <= 0;
         frame_valid <= 1'b0;
         frame <= '0;
      end
      else
      begin
         line_q <= line;
         frame_valid <= 1'b0;
         if (!busy)
         begin
            // fall happened on the previous edge
            if (line_q && !line)
            begin
               busy <= 1'b1;
               cnt <= 2;
               idx <= 0;
            end
         end
         else
         begin
            cnt <= cnt + 1;
            // middle of bit idx
            if (cnt == bit_clocks / 2 + idx * bit_clocks)
            begin
               frame[idx] <= line;
               idx <= idx + 1;
               if (idx == frame_bits - 1)
               begin
                  busy <= 1'b0;
                  frame_valid <= 1'b1;
               end
            end
         end
      end
   end

endmodule

// ==== tests/uart_tx_bank_tb.sv ====
// testbench for the uart transmit bank with line monitors, reference frames and verdict
module uart_tx_bank_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int nc = uart_pkg::num_channels;
   localparam int frame_bits = uart_pkg::data_bits + 2;
   localparam int bit_clocks = uart_pkg::oversample * uart_pkg::baud_divisor;
   localparam int rounds = 5;
   localparam int depth = 32;
   // single frames plus random rounds plus the overrun pair
   localparam int total_frames = nc + nc * rounds + 2;
   localparam int cycle_limit = total_frames * 700 + 2000;

   logic                           clk;
   logic                           reset;
   logic                           wr_en;
   logic [uart_pkg::chan_w-1:0]    wr_channel;
   logic [uart_pkg::data_bits-1:0] wr_data;
   logic [nc-1:0]                  done_clear;
   logic [nc-1:0]                  buf_full;
   logic                           overrun;
   logic [nc-1:0]                  tx;
   logic [nc-1:0]                  done_flags;
   logic                           irq;
   logic [uart_pkg::count_w-1:0]   sent_count;

   logic [nc-1:0]                  frame_valid;
   logic [frame_bits-1:0]          frame [nc];

   // bytes written per channel in order
   logic [uart_pkg::data_bits-1:0] queued [nc][depth];
   int                             wr_cnt [nc];
   int                             rd_cnt [nc];
   int                             accepted;
   int                             cycles = 0;
   logic [31:0]                    seed;
   string                          test_name;

   uart_tx_bank u_uart_tx_bank
   (
      .clk        (clk),
      .reset      (reset),
      .wr_en      (wr_en),
      .wr_channel (wr_channel),
      .wr_data    (wr_data),
      .done_clear (done_clear),
      .buf_full   (buf_full),
      .overrun    (overrun),
      .tx         (tx),
      .done_flags (done_flags),
      .irq        (irq),
      .sent_count (sent_count)
   );

   for (genvar ch = 0; ch < nc; ch++)
   begin : g_mon
      uart_line_monitor u_uart_line_monitor
      (
         .clk         (clk),
         .reset       (reset),
         .line        (tx[ch]),
         .frame_valid (frame_valid[ch]),
         .frame       (frame[ch])
      );
   end

   always #50 clk = ~clk;

   // stop bit high above lsb-first data above a low start bit
   function automatic logic [frame_bits-1:0] expected_frame(
      input logic [uart_pkg::data_bits-1:0] data);
      return {1'b1, data, 1'b0};
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic report_failure(input string what);
      $display("TEST FAILED");
      $display("%s", what);
      $fatal(1);
   endtask

   task automatic check_frame(input string name, input logic [frame_bits-1:0] exp,
                              input logic [frame_bits-1:0] act);
      if (act !== exp)
      begin
         report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
      end
   endtask

   task automatic check_flags(input string name, input logic [nc-1:0] exp,
                              input logic [nc-1:0] act);
      if (act !== exp)
      begin
         report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input logic [uart_pkg::count_w-1:0] exp,
                              input logic [uart_pkg::count_w-1:0] act);
      if (act !== exp)
      begin
         report_failure($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
      end
   endtask

   // waits for room and then strobes one write
   task automatic write_byte(input int ch, input logic [uart_pkg::data_bits-1:0] data);
      @(negedge clk);
      while (buf_full[ch])
      begin
         @(negedge clk);
      end
      @(posedge clk);
      wr_en <= 1'b1;
      wr_channel <= uart_pkg::chan_w'(ch);
      wr_data <= data;
      @(posedge clk);
      wr_en <= 1'b0;
      queued[ch][wr_cnt[ch] % depth] = data;
      wr_cnt[ch]++;
      accepted++;
      @(negedge clk);
      check_level($sformatf("%s overrun on write to ch%0d", test_name, ch), 1'b0, overrun);
   endtask

   task automatic write_dropped(input int ch, input logic [uart_pkg::data_bits-1:0] data);
      @(negedge clk);
      check_level($sformatf("%s buf_full ch%0d", test_name, ch), 1'b1, buf_full[ch]);
      @(posedge clk);
      wr_en <= 1'b1;
      wr_channel <= uart_pkg::chan_w'(ch);
      wr_data <= data;
      @(posedge clk);
      wr_en <= 1'b0;
      @(negedge clk);
      check_level($sformatf("%s overrun pulse ch%0d", test_name, ch), 1'b1, overrun);
   endtask

   task automatic wait_frames();
      bit pending;
      pending = 1'b1;
      while (pending)
      begin
         @(posedge clk);
         pending = 1'b0;
         for (int ch = 0; ch < nc; ch++)
         begin
            if (rd_cnt[ch] != wr_cnt[ch])
            begin
               pending = 1'b1;
            end
         end
      end
   endtask

   task automatic wait_done(input int ch);
      @(negedge clk);
      while (!done_flags[ch])
      begin
         @(negedge clk);
      end
   endtask

   task automatic clear_done(input logic [nc-1:0] mask);
      @(posedge clk);
      done_clear <= mask;
      @(posedge clk);
      done_clear <= '0;
      @(negedge clk);
   endtask

   // frame checker in write order per channel
   always @(negedge clk)
   begin
      for (int ch = 0; ch < nc; ch++)
      begin
         if (frame_valid[ch] === 1'b1)
         begin
            if (rd_cnt[ch] == wr_cnt[ch])
            begin
               report_failure($sformatf("a frame appeared on channel %0d with no byte written",
                                        ch));
            end
            else
            begin
               check_frame($sformatf("%s ch%0d frame %0d", test_name, ch, rd_cnt[ch]),
                           expected_frame(queued[ch][rd_cnt[ch] % depth]), frame[ch]);
               rd_cnt[ch]++;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         report_failure($sformatf("the run timed out after %0d clock cycles", cycles));
      end
   end

   initial
   begin
      logic [nc-1:0] finished;
      int            waited;

      clk = 1'b0;
      reset = 1'b1;
      wr_en = 1'b0;
      wr_channel = '0;
      wr_data = '0;
      done_clear = '0;
      accepted = 0;
      seed = 32'h437e_f440;
      test_name = "reset";
      for (int ch = 0; ch < nc; ch++)
      begin
         wr_cnt[ch] = 0;
         rd_cnt[ch] = 0;
      end
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      @(negedge clk);
      check_flags("reset tx", {nc{1'b1}}, tx);
      check_flags("reset buf_full", '0, buf_full);
      check_flags("reset done_flags", '0, done_flags);
      check_level("reset irq", 1'b0, irq);
      check_count("reset sent_count", '0, sent_count);

      // one byte per channel in turn
      test_name = "single";
      finished = '0;
      for (int ch = 0; ch < nc; ch++)
      begin
         seed = lcg_next(seed);
         write_byte(ch, seed[23:16]);
         check_level($sformatf("single buf_full ch%0d", ch), 1'b1, buf_full[ch]);
         while (tx[ch])
         begin
            @(negedge clk);
         end
         check_level($sformatf("single buf_full at start ch%0d", ch), 1'b0, buf_full[ch]);
         wait_done(ch);
         finished[ch] = 1'b1;
         check_flags("single done_flags", finished, done_flags);
      end

      test_name = "clear";
      check_level("clear irq before", 1'b1, irq);
      clear_done(4'b0101);
      check_flags("clear done_flags low pair", 4'b1010, done_flags);
      check_level("clear irq partial", 1'b1, irq);
      clear_done(4'b1010);
      check_flags("clear done_flags all", '0, done_flags);
      check_level("clear irq after", 1'b0, irq);

      test_name = "random";
      for (int r = 0; r < rounds; r++)
      begin
         for (int ch = 0; ch < nc; ch++)
         begin
            seed = lcg_next(seed);
            write_byte(ch, seed[23:16]);
         end
      end
      wait_frames();

      // held byte must survive a write to a full buffer
      test_name = "overrun";
      seed = lcg_next(seed);
      write_byte(2, seed[23:16]);
      seed = lcg_next(seed);
      write_byte(2, seed[23:16]);
      // complement of the held byte so a wrongly accepted write shows on the line
      write_dropped(2, ~seed[23:16]);
      wait_frames();

      test_name = "final";
      waited = 0;
      @(negedge clk);
      while (sent_count != uart_pkg::count_w'(accepted) && waited < bit_clocks)
      begin
         @(negedge clk);
         waited++;
      end
      check_count("final sent_count", uart_pkg::count_w'(accepted), sent_count);
      check_flags("final tx idle", {nc{1'b1}}, tx);
      check_flags("final buf_full", '0, buf_full);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== uart_tx_bank.f ====
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/tx_dispatch.sv
logic/uart_tx.sv
logic/tx_done_collector.sv
logic/uart_tx_bank.sv
tests/uart_line_monitor.sv
tests/uart_tx_bank_tb.sv

// ==== Makefile ====
# Verilator flow for the uart transmit bank

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f uart_tx_bank.f --top-module uart_tx_bank
	verilator --lint-only --timing --timescale 1ns/1ps -f uart_tx_bank.f --top-module uart_tx_bank_tb

sim:
	verilator --binary --timing --timescale 1ns/1ps -f uart_tx_bank.f \
		--top-module uart_tx_bank_tb -o uart_tx_bank_sim
	-./obj_dir/uart_tx_bank_sim > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
